// ==== hdl/ooo_core_params.svh ====
`ifndef OOO_CORE_PARAMS_SVH
`define OOO_CORE_PARAMS_SVH

// Data word width
`define XLEN 32

// Instruction queue depth and the sender's starting credit count
`define IQ_DEPTH 4

// Reorder buffer size is a power of two so tags wrap naturally
`define ROB_ENTRIES 8

// ALU reservation station slots
`define RS_ENTRIES 4

`endif

// ==== hdl/ooo_core_pkg.sv ====
package ooo_core_pkg;

    `include "ooo_core_params.svh"

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I-type view of the same word
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } rv32_instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_tag_t;

    // Value is valid once ready is set, otherwise wait on tag
    typedef struct packed {
        logic             ready;
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        operand_t src1;
        operand_t src2;
        rob_tag_t dest;
    } rs_entry_t;

    typedef struct packed {
        logic             valid;
        logic             done;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } rob_entry_t;

endpackage

// ==== hdl/ooo_core_if.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

// Allocation from dispatch into the ROB and the ALU station
interface dispatch_if import ooo_core_pkg::*; ();

    logic      rob_alloc;
    rob_tag_t  tag;
    logic [4:0] rd;
    logic      rs_push;
    rs_entry_t rs_entry;
    logic      rob_full;
    logic      rs_full;

    modport source (
        output rob_alloc, tag, rd, rs_push, rs_entry,
        input  rob_full, rs_full
    );

    modport rob (
        input  rob_alloc, tag, rd,
        output rob_full
    );

    modport station (
        input  rs_push, rs_entry,
        output rs_full
    );

endinterface

// Common data bus carrying one result per cycle
interface cdb_if import ooo_core_pkg::*; ();

    logic             valid;
    rob_tag_t         tag;
    logic [`XLEN-1:0] value;

    modport driver (output valid, tag, value);

    modport monitor (input valid, tag, value);

endinterface

// ==== hdl/instr_queue.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module instr_queue import ooo_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        push_i,
    input  rv32_instr_u instr_i,
    input  logic        pop_i,
    output logic        empty_o,
    output rv32_instr_u instr_o,
    output logic        credit_o
);

    localparam int ptr_w = $clog2(`IQ_DEPTH);
    localparam int cnt_w = $clog2(`IQ_DEPTH + 1);

    rv32_instr_u      mem_q [`IQ_DEPTH];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // A push into a full queue is a sender fault and is dropped
    assign do_push = push_i && (count_q != cnt_w'(`IQ_DEPTH));
    assign do_pop  = pop_i && !empty_o;
    assign empty_o = (count_q == '0);
    assign instr_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= instr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + cnt_w'(do_push) - cnt_w'(do_pop);
            // One credit back to the sender per freed slot
            credit_o <= do_pop;
        end
    end

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module dispatch import ooo_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   empty_i,
    input  rv32_instr_u            instr_i,
    output logic                   pop_o,
    output logic [4:0]             rs1_o,
    output logic [4:0]             rs2_o,
    input  logic [1:0]             src_busy_i,
    input  rob_tag_t [1:0]         src_tag_i,
    input  logic [1:0][`XLEN-1:0]  src_value_i,
    output logic                   rename_o,
    output logic [4:0]             rename_rd_o,
    output rob_tag_t               rename_tag_o,
    output rob_tag_t [1:0]         rob_peek_tag_o,
    input  logic [1:0]             rob_peek_done_i,
    input  logic [1:0][`XLEN-1:0]  rob_peek_value_i,
    dispatch_if.source             disp,
    cdb_if.monitor                 cdb
);

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    rob_tag_t         next_tag_q;
    alu_op_e          dec_op;
    logic [4:0]       dec_rd;
    logic             alt;
    logic             src1_zero;
    logic             src2_imm;
    logic [`XLEN-1:0] imm_val;
    operand_t [1:0]   resolved;
    operand_t         src1;
    operand_t         src2;

    assign pop_o = !empty_i && !disp.rob_full && !disp.rs_full;

    assign rs1_o          = instr_i.r_fields.rs1;
    assign rs2_o          = instr_i.r_fields.rs2;
    assign rob_peek_tag_o = src_tag_i;

    // Bit 30 selects sub and sra but only srai looks at it in OP-IMM
    assign alt = (instr_i.r_fields.opcode == opcode_op) ? instr_i.r_fields.funct7[5]
               : (instr_i.i_fields.funct3 == 3'b101) && instr_i.i_fields.imm12[10];

    always_comb begin
        dec_rd    = 5'd0;
        src1_zero = 1'b1;
        src2_imm  = 1'b1;
        imm_val   = '0;
        case (instr_i.r_fields.opcode)
            opcode_op: begin
                dec_rd    = instr_i.r_fields.rd;
                src1_zero = 1'b0;
                src2_imm  = 1'b0;
            end
            opcode_op_imm: begin
                dec_rd    = instr_i.i_fields.rd;
                src1_zero = 1'b0;
                imm_val   = {{(`XLEN-12){instr_i.i_fields.imm12[11]}}, instr_i.i_fields.imm12};
                // Shift amounts come from the low five immediate bits
                if (instr_i.i_fields.funct3 inside {3'b001, 3'b101}) begin
                    imm_val = {{(`XLEN-5){1'b0}}, instr_i.i_fields.imm12[4:0]};
                end
            end
            // Anything else becomes add x0, zero, zero
            default: ;
        endcase
    end

    always_comb begin
        case (instr_i.r_fields.funct3)
            3'b000: dec_op = alt ? alu_sub : alu_add;
            3'b001: dec_op = alu_sll;
            3'b010: dec_op = alu_slt;
            3'b011: dec_op = alu_sltu;
            3'b100: dec_op = alu_xor;
            3'b101: dec_op = alt ? alu_sra : alu_srl;
            3'b110: dec_op = alu_or;
            default: dec_op = alu_and;
        endcase
        if (src1_zero) begin
            dec_op = alu_add;
        end
    end

    // Operands come from the register file, then a finished ROB entry, then the live CDB
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            resolved[k] = '{ready: 1'b0, tag: src_tag_i[k], value: '0};
            if (!src_busy_i[k]) begin
                resolved[k].ready = 1'b1;
                resolved[k].value = src_value_i[k];
            end else if (rob_peek_done_i[k]) begin
                resolved[k].ready = 1'b1;
                resolved[k].value = rob_peek_value_i[k];
            end else if (cdb.valid && cdb.tag == src_tag_i[k]) begin
                resolved[k].ready = 1'b1;
                resolved[k].value = cdb.value;
            end
        end
    end

    assign src1 = src1_zero ? '{ready: 1'b1, tag: '0, value: '0} : resolved[0];
    assign src2 = src2_imm ? '{ready: 1'b1, tag: '0, value: imm_val} : resolved[1];

    assign disp.rob_alloc = pop_o;
    assign disp.tag       = next_tag_q;
    assign disp.rd        = dec_rd;
    assign disp.rs_push   = pop_o;
    assign disp.rs_entry  = '{valid: 1'b1, op: dec_op, src1: src1, src2: src2,
                              dest: next_tag_q};

    assign rename_o     = pop_o;
    assign rename_rd_o  = dec_rd;
    assign rename_tag_o = next_tag_q;

    // Tracks the ROB tail
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            next_tag_q <= '0;
        end else if (pop_o) begin
            next_tag_q <= next_tag_q + 1'b1;
        end
    end

endmodule

// ==== hdl/reg_status_file.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module reg_status_file import ooo_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [4:0]            rs1_i,
    input  logic [4:0]            rs2_i,
    output logic [1:0]            busy_o,
    output rob_tag_t [1:0]        tag_o,
    output logic [1:0][`XLEN-1:0] value_o,
    input  logic                  rename_i,
    input  logic [4:0]            rename_rd_i,
    input  rob_tag_t              rename_tag_i,
    input  logic                  commit_i,
    input  logic [4:0]            commit_rd_i,
    input  rob_tag_t              commit_tag_i,
    input  logic [`XLEN-1:0]      commit_value_i
);

    logic [`XLEN-1:0] regs_q [32];
    logic [31:0]      busy_q;
    rob_tag_t         tag_q  [32];

    // x0 is never written, so it stays zero and idle
    assign busy_o[0]  = busy_q[rs1_i];
    assign busy_o[1]  = busy_q[rs2_i];
    assign tag_o[0]   = tag_q[rs1_i];
    assign tag_o[1]   = tag_q[rs2_i];
    assign value_o[0] = regs_q[rs1_i];
    assign value_o[1] = regs_q[rs2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            if (commit_i && commit_rd_i != 5'd0) begin
                regs_q[commit_rd_i] <= commit_value_i;
                // Only the newest producer may release the register
                if (tag_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            // Rename comes last so it wins over a same-cycle commit
            if (rename_i && rename_rd_i != 5'd0) begin
                busy_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]  <= rename_tag_i;
            end
        end
    end

endmodule

// ==== hdl/alu_station.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module alu_station import ooo_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    dispatch_if.station disp,
    cdb_if.driver       cdb
);

    localparam int idx_w = $clog2(`RS_ENTRIES);

    rs_entry_t        slot_q [`RS_ENTRIES];
    rs_entry_t        slot_d [`RS_ENTRIES];
    logic             issue;
    logic [idx_w-1:0] issue_idx;

    function automatic logic [`XLEN-1:0] alu(alu_op_e op, logic [`XLEN-1:0] a,
                                              logic [`XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: return {{(`XLEN-1){1'b0}}, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic operand_t snoop(operand_t src, logic valid, rob_tag_t tag,
                                       logic [`XLEN-1:0] value);
        if (!src.ready && valid && src.tag == tag) begin
            src.ready = 1'b1;
            src.value = value;
        end
        return src;
    endfunction

    // Slots stay compacted toward index 0, so the lowest index is the oldest
    always_comb begin
        issue     = 1'b0;
        issue_idx = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (slot_q[i].valid && slot_q[i].src1.ready && slot_q[i].src2.ready) begin
                issue     = 1'b1;
                issue_idx = i[idx_w-1:0];
            end
        end
    end

    // Full only when the youngest position is occupied
    assign disp.rs_full = slot_q[`RS_ENTRIES-1].valid;

    always_comb begin
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            slot_d[i]      = slot_q[i];
            slot_d[i].src1 = snoop(slot_q[i].src1, cdb.valid, cdb.tag, cdb.value);
            slot_d[i].src2 = snoop(slot_q[i].src2, cdb.valid, cdb.tag, cdb.value);
        end
        // Close the gap left by the issued entry
        if (issue) begin
            for (int i = 0; i < `RS_ENTRIES - 1; i++) begin
                if (i >= int'(issue_idx)) begin
                    slot_d[i] = slot_d[i+1];
                end
            end
            slot_d[`RS_ENTRIES-1].valid = 1'b0;
        end
        if (disp.rs_push) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (!placed && !slot_d[i].valid) begin
                    slot_d[i] = disp.rs_entry;
                    placed    = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                slot_q[i] <= '0;
            end
            cdb.valid <= 1'b0;
        end else begin
            slot_q    <= slot_d;
            cdb.valid <= issue;
        end
    end

    // Result goes out on the CDB the cycle after issue
    always_ff @(posedge clk) begin
        if (issue) begin
            cdb.tag   <= slot_q[issue_idx].dest;
            cdb.value <= alu(slot_q[issue_idx].op, slot_q[issue_idx].src1.value,
                             slot_q[issue_idx].src2.value);
        end
    end

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module reorder_buffer import ooo_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    dispatch_if.rob               disp,
    cdb_if.monitor                cdb,
    input  rob_tag_t [1:0]        peek_tag_i,
    output logic [1:0]            peek_done_o,
    output logic [1:0][`XLEN-1:0] peek_value_o,
    output logic                  commit_valid_o,
    output logic [4:0]            commit_rd_o,
    output rob_tag_t              commit_tag_o,
    output logic [`XLEN-1:0]      commit_value_o
);

    localparam int cnt_w = $clog2(`ROB_ENTRIES + 1);

    rob_entry_t       rob_q [`ROB_ENTRIES];
    rob_tag_t         head_q;
    logic [cnt_w-1:0] count_q;
    logic             retire;

    assign disp.rob_full = (count_q == cnt_w'(`ROB_ENTRIES));
    assign retire        = rob_q[head_q].valid && rob_q[head_q].done;

    // Done and value outlive retirement until the slot is reallocated,
    // which covers the cycle before the register file takes the commit
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            peek_done_o[k]  = rob_q[peek_tag_i[k]].done;
            peek_value_o[k] = rob_q[peek_tag_i[k]].value;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ROB_ENTRIES; i++) begin
                rob_q[i] <= '0;
            end
            head_q         <= '0;
            count_q        <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            // Dispatch writes at its own tail tag
            if (disp.rob_alloc) begin
                rob_q[disp.tag] <= '{valid: 1'b1, done: 1'b0, rd: disp.rd, value: '0};
            end
            if (cdb.valid && rob_q[cdb.tag].valid) begin
                rob_q[cdb.tag].done  <= 1'b1;
                rob_q[cdb.tag].value <= cdb.value;
            end
            if (retire) begin
                rob_q[head_q].valid <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
            count_q        <= count_q + cnt_w'(disp.rob_alloc) - cnt_w'(retire);
            commit_valid_o <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_rd_o    <= rob_q[head_q].rd;
            commit_tag_o   <= head_q;
            commit_value_o <= rob_q[head_q].value;
        end
    end

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module ooo_core import ooo_core_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    output logic             credit_o,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output logic [`XLEN-1:0] commit_value_o
);

    logic                  iq_empty;
    logic                  iq_pop;
    rv32_instr_u           iq_instr;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [1:0]            src_busy;
    rob_tag_t [1:0]        src_tag;
    logic [1:0][`XLEN-1:0] src_value;
    logic                  rename;
    logic [4:0]            rename_rd;
    rob_tag_t              rename_tag;
    rob_tag_t [1:0]        peek_tag;
    logic [1:0]            peek_done;
    logic [1:0][`XLEN-1:0] peek_value;
    rob_tag_t              commit_tag;

    dispatch_if disp_bus ();
    cdb_if      cdb_bus ();

    instr_queue iq (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .push_i   (instr_valid_i),
        .instr_i  (instr_i),
        .pop_i    (iq_pop),
        .empty_o  (iq_empty),
        .instr_o  (iq_instr),
        .credit_o (credit_o)
    );

    dispatch decode (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .empty_i          (iq_empty),
        .instr_i          (iq_instr),
        .pop_o            (iq_pop),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .src_busy_i       (src_busy),
        .src_tag_i        (src_tag),
        .src_value_i      (src_value),
        .rename_o         (rename),
        .rename_rd_o      (rename_rd),
        .rename_tag_o     (rename_tag),
        .rob_peek_tag_o   (peek_tag),
        .rob_peek_done_i  (peek_done),
        .rob_peek_value_i (peek_value),
        .disp             (disp_bus.source),
        .cdb              (cdb_bus.monitor)
    );

    reg_status_file reg_file (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .busy_o         (src_busy),
        .tag_o          (src_tag),
        .value_o        (src_value),
        .rename_i       (rename),
        .rename_rd_i    (rename_rd),
        .rename_tag_i   (rename_tag),
        .commit_i       (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_tag_i   (commit_tag),
        .commit_value_i (commit_value_o)
    );

    alu_station alu_rs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .disp    (disp_bus.station),
        .cdb     (cdb_bus.driver)
    );

    reorder_buffer rob (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .disp           (disp_bus.rob),
        .cdb            (cdb_bus.monitor),
        .peek_tag_i     (peek_tag),
        .peek_done_o    (peek_done),
        .peek_value_o   (peek_value),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag),
        .commit_value_o (commit_value_o)
    );

endmodule

// ==== bench/ooo_core_assert.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module ooo_core_assert (
    input logic             clk,
    input logic             rst_n_i,
    input logic             credit_i,
    input logic             commit_valid_i,
    input logic [4:0]       commit_rd_i,
    input logic [`XLEN-1:0] commit_value_i,
    input logic             exp_empty_i,
    input logic [4:0]       exp_rd_i,
    input logic [`XLEN-1:0] exp_value_i,
    input int               credits_i,
    input logic             idle_i
);

    int fail_count = 0;

    // Outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n_i |-> (!credit_i && !commit_valid_i))
    else begin
        fail_count++;
        $error("credit or commit output active during reset at %0t", $time);
    end

    commit_expected: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> !exp_empty_i)
    else begin
        fail_count++;
        $error("commit arrived at %0t with no instruction outstanding", $time);
    end

    // Retirement in program order against the golden model
    commit_match: assert property (@(posedge clk) disable iff (!rst_n_i)
        (commit_valid_i && !exp_empty_i) |->
            (commit_rd_i == exp_rd_i && commit_value_i == exp_value_i))
    else begin
        fail_count++;
        $error("MISMATCH %0t: commit rd %0d value %h, expected rd %0d value %h", $time,
               $sampled(commit_rd_i), $sampled(commit_value_i),
               $sampled(exp_rd_i), $sampled(exp_value_i));
    end

    credit_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        credits_i >= 0 && credits_i <= `IQ_DEPTH)
    else begin
        fail_count++;
        $error("sender credit count %0d left the legal range", $sampled(credits_i));
    end

    // Once drained, every credit has come back
    credit_return: assert property (@(posedge clk) disable iff (!rst_n_i)
        idle_i |-> credits_i == `IQ_DEPTH)
    else begin
        fail_count++;
        $error("only %0d credits returned after the core went idle", $sampled(credits_i));
    end

endmodule

// ==== bench/tb_ooo_core.sv ====
`timescale 1ns/1ps

`include "ooo_core_params.svh"

module tb_ooo_core;

    localparam int         total_instr = 148;
    localparam logic [6:0] op_reg      = 7'b0110011;
    localparam logic [6:0] op_imm      = 7'b0010011;
    localparam logic [2:0] f_add       = 3'd0;
    localparam logic [2:0] f_sll       = 3'd1;
    localparam logic [2:0] f_or        = 3'd6;
    localparam logic [2:0] f_srl       = 3'd5;

    logic             clk;
    logic             rst_n_i;
    logic             instr_valid_i;
    logic [31:0]      instr_i;
    logic             credit_o;
    logic             commit_valid_o;
    logic [4:0]       commit_rd_o;
    logic [`XLEN-1:0] commit_value_o;

    logic [`XLEN-1:0] gold_regs [32];
    logic [4:0]       exp_rd_mem [total_instr];
    logic [`XLEN-1:0] exp_val_mem [total_instr];
    int               exp_wr_ptr = 0;
    int               exp_rd_ptr = 0;
    logic             exp_empty;
    logic [4:0]       exp_rd_head;
    logic [`XLEN-1:0] exp_value_head;
    int               credits = `IQ_DEPTH;
    int               commits = 0;
    int               sent = 0;
    int               tests = 0;
    logic             idle;
    logic [15:0]      lfsr_q = 16'd29;

    ooo_core UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .credit_o       (credit_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    bind ooo_core ooo_core_assert chk (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .credit_i       (credit_o),
        .commit_valid_i (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_value_i (commit_value_o),
        .exp_empty_i    (tb_ooo_core.exp_empty),
        .exp_rd_i       (tb_ooo_core.exp_rd_head),
        .exp_value_i    (tb_ooo_core.exp_value_head),
        .credits_i      (tb_ooo_core.credits),
        .idle_i         (tb_ooo_core.idle)
    );

    assign exp_empty      = (exp_rd_ptr == exp_wr_ptr);
    assign exp_rd_head    = exp_empty ? 5'd0 : exp_rd_mem[exp_rd_ptr];
    assign exp_value_head = exp_empty ? '0 : exp_val_mem[exp_rd_ptr];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    // RV32I OP and OP-IMM semantics with zero for anything else
    function automatic logic [`XLEN-1:0] alu_model(logic [31:0] w, logic [`XLEN-1:0] a,
                                                   logic [`XLEN-1:0] r2);
        logic [`XLEN-1:0] b;
        logic [4:0]       sh;
        if (w[6:0] != op_reg && w[6:0] != op_imm) begin
            return '0;
        end
        b  = (w[6:0] == op_imm) ? {{20{w[31]}}, w[31:20]} : r2;
        sh = b[4:0];
        case (w[14:12])
            3'd0: return (w[6:0] == op_reg && w[30]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Sender side of the credit loop
    always @(negedge clk) begin
        if (credit_o) begin
            credits = credits + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            commits <= commits + 1;
            if (!exp_empty) begin
                exp_rd_ptr <= exp_rd_ptr + 1;
            end
        end
    end

    task automatic send(input logic [31:0] word);
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
        @(negedge clk);
        while (credits == 0) begin
            instr_valid_i = 1'b0;
            @(negedge clk);
        end
        instr_valid_i = 1'b1;
        instr_i       = word;
        credits       = credits - 1;
        value = alu_model(word, gold_regs[word[19:15]], gold_regs[word[24:20]]);
        rd    = (word[6:0] == op_reg || word[6:0] == op_imm) ? word[11:7] : 5'd0;
        if (rd != 5'd0) begin
            gold_regs[rd] = value;
        end
        exp_rd_mem[exp_wr_ptr]  = rd;
        exp_val_mem[exp_wr_ptr] = value;
        exp_wr_ptr++;
        sent++;
    endtask

    task automatic send_op(input logic is_imm, input logic [2:0] f3, input logic alt,
                           input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        // Shift immediates carry only shamt and the sra bit
        if (f3 == f_sll || f3 == f_srl) begin
            field = {1'b0, alt, 5'b0, imm[4:0]};
        end
        if (is_imm) begin
            send({field, rs1, f3, rd, op_imm});
        end else begin
            send({1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg});
        end
    endtask

    task automatic send_random();
        logic        is_imm;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        is_imm = 1'(rand_bits(1));
        f3     = 3'(rand_bits(3));
        alt    = 1'(rand_bits(1)) && (f3 == f_srl || (f3 == f_add && !is_imm));
        rd     = 5'(rand_bits(4));
        rs1    = 5'(rand_bits(4));
        rs2    = 5'(rand_bits(4));
        imm    = 12'(rand_bits(12));
        send_op(is_imm, f3, alt, rd, rs1, rs2, imm);
    endtask

    task automatic wait_commits(input int n);
        @(negedge clk);
        instr_valid_i = 1'b0;
        while (commits < n) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        instr_valid_i = 1'b0;
        while (!exp_empty) begin
            @(negedge clk);
        end
        idle = 1'b1;
        repeat (3) @(negedge clk);
        idle = 1'b0;
        tests++;
        $display("test %0d %s: %0d instructions committed so far, %0d assertion failures",
                 tests, name, commits, UUT.chk.fail_count);
    endtask

    initial begin
        repeat (10 + total_instr * 20) @(posedge clk);
        $display("TIMEOUT: the core stopped committing after %0d of %0d instructions",
                 commits, sent);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        idle          = 1'b0;
        for (int i = 0; i < 32; i++) begin
            gold_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        // Operand setup followed by every operation once
        send_op(1, f_add, 0, 5'd1, 5'd0, 5'd0, 12'hFFD);
        send_op(1, f_add, 0, 5'd2, 5'd0, 5'd0, 12'h7A5);
        send_op(1, f_sll, 0, 5'd3, 5'd2, 5'd0, 12'd20);
        send_op(1, f_add, 0, 5'd4, 5'd0, 5'd0, 12'd13);
        for (int f = 0; f < 8; f++) begin
            send_op(0, 3'(f), 0, 5'(5 + f), 5'd1, 5'd4, 12'd0);
        end
        send_op(0, f_add, 1, 5'd13, 5'd3, 5'd4, 12'd0);
        send_op(0, f_srl, 1, 5'd14, 5'd1, 5'd4, 12'd0);
        for (int f = 0; f < 8; f++) begin
            send_op(1, 3'(f), 0, 5'(16 + f), (f % 2) ? 5'd3 : 5'd1, 5'd0, 12'h9A5 + 12'(f));
        end
        send_op(1, f_srl, 1, 5'd24, 5'd1, 5'd0, 12'd9);
        finish_test("independent operations");

        // Each step reads the previous result
        send_op(1, f_add, 0, 5'd26, 5'd0, 5'd0, 12'd77);
        for (int k = 0; k < 15; k++) begin
            send_op(k % 2, 3'(k % 8), (k == 8) || (k == 13), 5'd26, 5'd26, 5'd2,
                    12'(k * 37 + 100));
        end
        finish_test("dependency chain");

        send_op(0, f_add, 0, 5'd0, 5'd1, 5'd2, 12'd0);
        send_op(1, f_add, 0, 5'd0, 5'd0, 5'd0, 12'd55);
        send_op(0, f_add, 0, 5'd27, 5'd0, 5'd0, 12'd0);
        send_op(1, f_or, 0, 5'd28, 5'd0, 5'd0, 12'd9);
        // Load opcode is outside the supported groups
        send({12'h004, 5'd1, 3'b010, 5'd29, 7'b0000011});
        send_op(0, f_add, 0, 5'd29, 5'd29, 5'd0, 12'd0);
        finish_test("x0 writes and reads");

        // The younger x30 write waits on a chain so the older one commits first
        send_op(1, f_add, 0, 5'd30, 5'd0, 5'd0, 12'd11);
        for (int k = 0; k < 3; k++) begin
            send_op(0, f_add, 0, 5'd25, 5'd25, 5'd2, 12'd0);
        end
        send_op(0, f_add, 1, 5'd30, 5'd25, 5'd2, 12'd0);
        wait_commits(sent - 4);
        send_op(0, f_add, 0, 5'd31, 5'd30, 5'd0, 12'd0);
        send_op(0, f_add, 1, 5'd31, 5'd31, 5'd30, 12'd0);
        finish_test("write after write");

        // Serial chain keeps the station and ROB full
        for (int k = 0; k < 32; k++) begin
            if (k % 2 == 0) begin
                send_op(0, f_add, 0, 5'd8, 5'd8, 5'd9, 12'd0);
            end else begin
                send_op(0, 3'd4, 0, 5'd9, 5'd9, 5'd8, 12'd0);
            end
        end
        finish_test("back-pressure burst");

        repeat (64) send_random();
        finish_test("random mix");

        $display("summary: %0d tests, %0d sent, %0d committed, %0d assertion failures",
                 tests, sent, commits, UUT.chk.fail_count);
        if (UUT.chk.fail_count == 0 && commits == sent) begin
            $display("NO ERRORS");
        end else begin
            if (commits != sent) begin
                $display("commit count does not match the number of instructions sent");
            end
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== ooo_core.f ====
+incdir+hdl
hdl/ooo_core_pkg.sv
hdl/ooo_core_if.sv
hdl/instr_queue.sv
hdl/dispatch.sv
hdl/reg_status_file.sv
hdl/alu_station.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/ooo_core_assert.sv
bench/tb_ooo_core.sv
